// ==== Makefile ====
# Verilator build and run of the memory unit testbench.
# Any variable can be overridden on the command line, e.g. make run LOG=my.log

VERILATOR ?= verilator
TOP       ?= mem_tb
FILELIST  ?= mem.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Regression passed
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := testbench/mem_tb_ref.svh
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "no pass message in $(LOG)"; exit 1)
	@echo "pass message found in $(LOG)"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== common/mem_pkg.sv ====
package mem_pkg;

    // ======================================================================
    // widths
    // ======================================================================

    localparam int ADDR_W   = 16;  // word address.
    localparam int DATA_W   = 32;
    localparam int ROB_ID_W = 5;

    typedef logic [ADDR_W-1:0]   t_addr;
    typedef logic [DATA_W-1:0]   t_data;
    typedef logic [ROB_ID_W-1:0] t_rob_id;

    // ======================================================================
    // state machines
    // ======================================================================

    // load queue entry life cycle.
    typedef enum logic [2:0] {
        LQ_FREE,
        LQ_DISP,       // dispatched, address not known yet.
        LQ_READY,      // waiting for the pipe.
        LQ_INPIPE,
        LQ_WAIT_FILL   // missed, sleeps until a fill lands.
    } t_lq_state;

    // outcome of a load at mm3.
    typedef enum logic [1:0] {
        ACT_NONE,
        ACT_COMPLETE,
        ACT_REPLAY
    } t_pipe_action;

    // four-phase fill handshake.
    typedef enum logic [1:0] {
        FILL_IDLE,
        FILL_REQ,
        FILL_DROP      // written, waiting for ack to fall.
    } t_fill_state;

endpackage

// ==== loadq/loadq.sv ====
`timescale 1ns/1ns

module loadq #(
    parameter  int LQ_DEPTH = 8,
    localparam int IDX_W    = $clog2(LQ_DEPTH)
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 nuke_valid,

    input  logic                 disp_valid,
    input  mem_pkg::t_rob_id     disp_rob_id,
    output logic                 disp_ready,

    input  logic                 iss_valid,
    input  mem_pkg::t_rob_id     iss_rob_id,
    input  mem_pkg::t_addr       iss_addr,

    output logic                 pipe_req,
    output mem_pkg::t_rob_id     pipe_req_rob_id,
    output mem_pkg::t_addr       pipe_req_addr,
    output logic [IDX_W-1:0]     pipe_req_idx,
    input  logic                 pipe_gnt,

    input  logic                 valid_mm3,
    input  mem_pkg::t_pipe_action action_mm3,
    input  logic [IDX_W-1:0]     idx_mm3,
    input  logic                 fill_done
);

import mem_pkg::*;

t_lq_state            state_q   [LQ_DEPTH];
t_rob_id              rob_id_q  [LQ_DEPTH];
t_addr                addr_q    [LQ_DEPTH];
logic [LQ_DEPTH-1:0]  fill_seen_q;  // a fill landed while the entry was in the pipe.

logic [LQ_DEPTH-1:0]  free_vec;
logic [LQ_DEPTH-1:0]  free_left;
logic [LQ_DEPTH-1:0]  ready_vec;
logic [LQ_DEPTH-1:0]  iss_match;
logic [IDX_W-1:0]     alloc_idx;
logic [IDX_W-1:0]     sel_idx;
logic                 disp_fire;
logic                 gnt_fire;

// ======================================================================
// entry scan and arbitration
// ======================================================================

always_comb begin
    free_vec  = '0;
    ready_vec = '0;
    iss_match = '0;
    for (int i = 0; i < LQ_DEPTH; i++) begin
        free_vec[i]  = (state_q[i] == LQ_FREE);
        ready_vec[i] = (state_q[i] == LQ_READY);
        iss_match[i] = iss_valid && (state_q[i] == LQ_DISP) && (rob_id_q[i] == iss_rob_id);
    end
end

// lowest index wins, both for allocation and for the pipe.
always_comb begin
    alloc_idx = '0;
    sel_idx   = '0;
    for (int i = LQ_DEPTH - 1; i >= 0; i--) begin
        if (free_vec[i]) begin
            alloc_idx = IDX_W'(i);
        end
        if (ready_vec[i]) begin
            sel_idx = IDX_W'(i);
        end
    end
end

assign disp_fire       = disp_valid && disp_ready;
assign gnt_fire        = pipe_req && pipe_gnt;
assign pipe_req        = |ready_vec;
assign pipe_req_rob_id = rob_id_q[sel_idx];
assign pipe_req_addr   = addr_q[sel_idx];
assign pipe_req_idx    = sel_idx;

always_comb begin
    free_left = free_vec;
    if (disp_fire) begin
        free_left[alloc_idx] = 1'b0;
    end
end

// ready next cycle if any entry is free after this edge.
always_ff @(posedge clk) begin
    if (reset) begin
        disp_ready <= 1'b0;
    end else begin
        disp_ready <= nuke_valid || (|free_left) ||
                      (valid_mm3 && action_mm3 == ACT_COMPLETE);
    end
end

// ======================================================================
// entry state
// ======================================================================

always_ff @(posedge clk) begin
    for (int i = 0; i < LQ_DEPTH; i++) begin
        if (reset || nuke_valid) begin
            state_q[i]     <= LQ_FREE;
            fill_seen_q[i] <= 1'b0;
        end else begin
            case (state_q[i])
                LQ_FREE: begin
                    if (disp_fire && alloc_idx == IDX_W'(i)) begin
                        state_q[i] <= LQ_DISP;
                    end
                end
                LQ_DISP: begin
                    if (iss_match[i]) begin
                        state_q[i] <= LQ_READY;
                    end
                end
                LQ_READY: begin
                    if (gnt_fire && sel_idx == IDX_W'(i)) begin
                        state_q[i]     <= LQ_INPIPE;
                        fill_seen_q[i] <= 1'b0;
                    end
                end
                LQ_INPIPE: begin
                    if (fill_done) begin
                        fill_seen_q[i] <= 1'b1;
                    end
                    if (valid_mm3 && idx_mm3 == IDX_W'(i)) begin
                        if (action_mm3 == ACT_COMPLETE) begin
                            state_q[i] <= LQ_FREE;
                        end else if (action_mm3 == ACT_REPLAY) begin
                            // the read may predate a fill, so retry at once.
                            state_q[i] <= (fill_seen_q[i] || fill_done) ? LQ_READY
                                                                        : LQ_WAIT_FILL;
                        end
                    end
                end
                LQ_WAIT_FILL: begin
                    if (fill_done) begin
                        state_q[i] <= LQ_READY;  // any fill wakes every sleeper.
                    end
                end
                default: state_q[i] <= LQ_FREE;
            endcase
        end
    end
end

always_ff @(posedge clk) begin
    for (int i = 0; i < LQ_DEPTH; i++) begin
        if (disp_fire && free_vec[i] && alloc_idx == IDX_W'(i)) begin
            rob_id_q[i] <= disp_rob_id;
        end
        if (iss_match[i]) begin
            addr_q[i] <= iss_addr;
        end
    end
end

a_iss_one_match: assert property (@(posedge clk) disable iff (reset)
    iss_valid && !nuke_valid |-> $onehot(iss_match));

// registered ready must agree with the entries of this cycle.
a_disp_has_room: assert property (@(posedge clk) disable iff (reset)
    disp_valid && disp_ready |-> |free_vec);

endmodule

// ==== mem.f ====
+incdir+testbench
common/mem_pkg.sv
loadq/loadq.sv
mempipe/mempipe.sv
rtl/l1_array.sv
rtl/mem.sv
testbench/mem_tb.sv

// ==== mempipe/mempipe.sv ====
`timescale 1ns/1ns

module mempipe #(
    parameter  int LQ_DEPTH = 8,
    parameter  int L1_SETS  = 16,
    localparam int IDX_W    = $clog2(LQ_DEPTH),
    localparam int INDEX_W  = $clog2(L1_SETS),
    localparam int TAG_W    = mem_pkg::ADDR_W - INDEX_W
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  nuke_valid,

    input  logic                  pipe_req,
    input  mem_pkg::t_rob_id      pipe_req_rob_id,
    input  mem_pkg::t_addr        pipe_req_addr,
    input  logic [IDX_W-1:0]      pipe_req_idx,
    output logic                  pipe_gnt,
    input  logic                  fill_write,

    output logic                  rd_en,
    output mem_pkg::t_addr        rd_addr,
    input  logic [TAG_W-1:0]      rd_tag,
    input  logic                  rd_valid,
    input  mem_pkg::t_data        rd_data,

    output logic                  valid_mm3,
    output mem_pkg::t_pipe_action action_mm3,
    output logic [IDX_W-1:0]      idx_mm3,

    output logic                  complete_valid,
    output mem_pkg::t_rob_id      complete_rob_id,
    output mem_pkg::t_data        complete_data,

    output logic                  miss_valid,
    output mem_pkg::t_addr        miss_addr
);

import mem_pkg::*;

logic             take_mm0;

logic             valid_mm1;
t_rob_id          rob_id_mm1;
t_addr            addr_mm1;
logic [IDX_W-1:0] idx_mm1;

logic             valid_mm2;
t_rob_id          rob_id_mm2;
t_addr            addr_mm2;
logic [IDX_W-1:0] idx_mm2;
logic [TAG_W-1:0] tag_mm2;
logic             tag_valid_mm2;
t_data            data_mm2;
logic             hit_mm2;

// ======================================================================
// mm0: grant and array read
// ======================================================================

assign pipe_gnt = !fill_write;  // array port belongs to the fill this cycle.
assign take_mm0 = pipe_req && pipe_gnt;
assign rd_en    = take_mm0;
assign rd_addr  = pipe_req_addr;

// ======================================================================
// mm1 to mm3
// ======================================================================

assign hit_mm2 = tag_valid_mm2 && (tag_mm2 == addr_mm2[ADDR_W-1:INDEX_W]);

always_ff @(posedge clk) begin
    if (reset || nuke_valid) begin
        valid_mm1      <= 1'b0;
        valid_mm2      <= 1'b0;
        valid_mm3      <= 1'b0;
        action_mm3     <= ACT_NONE;
        complete_valid <= 1'b0;
        miss_valid     <= 1'b0;
    end else begin
        valid_mm1      <= take_mm0;
        valid_mm2      <= valid_mm1;
        valid_mm3      <= valid_mm2;
        action_mm3     <= !valid_mm2 ? ACT_NONE :
                          hit_mm2    ? ACT_COMPLETE : ACT_REPLAY;
        complete_valid <= valid_mm2 && hit_mm2;
        miss_valid     <= valid_mm2 && !hit_mm2;
    end
end

// payload follows the valids.
always_ff @(posedge clk) begin
    rob_id_mm1      <= pipe_req_rob_id;
    addr_mm1        <= pipe_req_addr;
    idx_mm1         <= pipe_req_idx;

    rob_id_mm2      <= rob_id_mm1;
    addr_mm2        <= addr_mm1;
    idx_mm2         <= idx_mm1;
    tag_mm2         <= rd_tag;     // array output is registered already.
    tag_valid_mm2   <= rd_valid;
    data_mm2        <= rd_data;

    idx_mm3         <= idx_mm2;
    complete_rob_id <= rob_id_mm2;
    complete_data   <= data_mm2;
    miss_addr       <= addr_mm2;
end

// no load may enter mm1 out of a fill-write cycle.
a_no_gnt_on_fill: assert property (@(posedge clk) disable iff (reset)
    fill_write |=> !valid_mm1);

endmodule

// ==== rtl/l1_array.sv ====
`timescale 1ns/1ns

module l1_array #(
    parameter  int L1_SETS = 16,
    localparam int INDEX_W = $clog2(L1_SETS),
    localparam int TAG_W   = mem_pkg::ADDR_W - INDEX_W
) (
    input  logic             clk,
    input  logic             reset,

    input  logic             rd_en,
    input  mem_pkg::t_addr   rd_addr,
    output logic [TAG_W-1:0] rd_tag,
    output logic             rd_valid,
    output mem_pkg::t_data   rd_data,

    input  logic             miss_valid,
    input  mem_pkg::t_addr   miss_addr,
    output logic             fill_write,
    output logic             fill_done,

    output logic             fill_req,
    output mem_pkg::t_addr   fill_addr,
    input  logic             fill_ack,
    input  mem_pkg::t_data   fill_data
);

import mem_pkg::*;

logic [L1_SETS-1:0] valid_q;
logic [TAG_W-1:0]   tag_q  [L1_SETS];
t_data              data_q [L1_SETS];

t_fill_state        fill_state;
logic               miss_pend;  // miss seen while ack was still high.
logic [INDEX_W-1:0] rd_index;
logic [INDEX_W-1:0] fill_index;

assign rd_index   = rd_addr[INDEX_W-1:0];
assign fill_index = fill_addr[INDEX_W-1:0];

// ======================================================================
// storage
// ======================================================================

always_ff @(posedge clk) begin
    if (rd_en) begin
        rd_tag   <= tag_q[rd_index];
        rd_valid <= valid_q[rd_index];
        rd_data  <= data_q[rd_index];
    end
end

always_ff @(posedge clk) begin
    if (reset) begin
        valid_q <= '0;
    end else if (fill_write) begin
        valid_q[fill_index] <= 1'b1;
    end
end

always_ff @(posedge clk) begin
    if (fill_write) begin
        tag_q[fill_index]  <= fill_addr[ADDR_W-1:INDEX_W];
        data_q[fill_index] <= fill_data;
    end
end

// ======================================================================
// fill handshake
// ======================================================================

assign fill_req   = (fill_state == FILL_REQ);
assign fill_write = fill_req && fill_ack;  // line lands on the ack edge.
assign fill_done  = fill_write;

always_ff @(posedge clk) begin
    if (reset) begin
        fill_state <= FILL_IDLE;
        miss_pend  <= 1'b0;
    end else begin
        case (fill_state)
            FILL_IDLE: begin
                if (miss_valid) begin
                    fill_state <= FILL_REQ;
                end
            end
            FILL_REQ: begin
                if (fill_ack) begin
                    fill_state <= FILL_DROP;
                end
            end
            FILL_DROP: begin
                if (!fill_ack) begin
                    // a late miss goes out as soon as the port is quiet.
                    fill_state <= (miss_pend || miss_valid) ? FILL_REQ : FILL_IDLE;
                    miss_pend  <= 1'b0;
                end else if (miss_valid) begin
                    miss_pend <= 1'b1;
                end
            end
            default: fill_state <= FILL_IDLE;
        endcase
    end
end

// misses during a request are dropped, the coming fill wakes them.
always_ff @(posedge clk) begin
    if (miss_valid && fill_state != FILL_REQ) begin
        fill_addr <= miss_addr;
    end
end

a_fill_addr_stable: assert property (@(posedge clk) disable iff (reset)
    fill_req |=> !fill_req || $stable(fill_addr));

endmodule

// ==== rtl/mem.sv ====
`timescale 1ns/1ns

module mem #(
    parameter int LQ_DEPTH = 8,
    parameter int L1_SETS  = 16
) (
    input  logic             clk,
    input  logic             reset,

    input  logic             disp_valid,
    input  mem_pkg::t_rob_id disp_rob_id,
    output logic             disp_ready,

    input  logic             iss_valid,
    input  mem_pkg::t_rob_id iss_rob_id,
    input  mem_pkg::t_addr   iss_addr,

    input  logic             nuke_valid,

    output logic             complete_valid,
    output mem_pkg::t_rob_id complete_rob_id,
    output mem_pkg::t_data   complete_data,

    output logic             fill_req,
    output mem_pkg::t_addr   fill_addr,
    input  logic             fill_ack,
    input  mem_pkg::t_data   fill_data
);

import mem_pkg::*;

localparam int IDX_W = $clog2(LQ_DEPTH);
localparam int TAG_W = ADDR_W - $clog2(L1_SETS);

// queue to pipe.
logic             pipe_req;
t_rob_id          pipe_req_rob_id;
t_addr            pipe_req_addr;
logic [IDX_W-1:0] pipe_req_idx;
logic             pipe_gnt;

// pipe back to queue.
logic             valid_mm3;
t_pipe_action     action_mm3;
logic [IDX_W-1:0] idx_mm3;

// pipe to array.
logic             rd_en;
t_addr            rd_addr;
logic [TAG_W-1:0] rd_tag;
logic             rd_valid;
t_data            rd_data;
logic             miss_valid;
t_addr            miss_addr;
logic             fill_write;
logic             fill_done;

loadq #(.LQ_DEPTH(LQ_DEPTH)) i_loadq (
    .clk,
    .reset,
    .nuke_valid,
    .disp_valid,
    .disp_rob_id,
    .disp_ready,
    .iss_valid,
    .iss_rob_id,
    .iss_addr,
    .pipe_req,
    .pipe_req_rob_id,
    .pipe_req_addr,
    .pipe_req_idx,
    .pipe_gnt,
    .valid_mm3,
    .action_mm3,
    .idx_mm3,
    .fill_done
);

mempipe #(.LQ_DEPTH(LQ_DEPTH), .L1_SETS(L1_SETS)) i_mempipe (
    .clk,
    .reset,
    .nuke_valid,
    .pipe_req,
    .pipe_req_rob_id,
    .pipe_req_addr,
    .pipe_req_idx,
    .pipe_gnt,
    .fill_write,
    .rd_en,
    .rd_addr,
    .rd_tag,
    .rd_valid,
    .rd_data,
    .valid_mm3,
    .action_mm3,
    .idx_mm3,
    .complete_valid,
    .complete_rob_id,
    .complete_data,
    .miss_valid,
    .miss_addr
);

l1_array #(.L1_SETS(L1_SETS)) i_l1_array (
    .clk,
    .reset,
    .rd_en,
    .rd_addr,
    .rd_tag,
    .rd_valid,
    .rd_data,
    .miss_valid,
    .miss_addr,
    .fill_write,
    .fill_done,
    .fill_req,
    .fill_addr,
    .fill_ack,
    .fill_data
);

endmodule

// ==== testbench/mem_tb_ref.svh ====
`ifndef MEM_TB_REF_SVH
`define MEM_TB_REF_SVH

// ======================================================================
// reference memory
// ======================================================================

// fixed mix of the whole word address.
function automatic t_data ref_mem_word(input t_addr addr);
    t_data h;
    h = {addr ^ 16'h5ac3, addr};
    h = h * 32'h0100_0193;
    h = h ^ (h >> 13) ^ 32'h1b87_3593;
    return h;
endfunction

// ======================================================================
// per-load bookkeeping, indexed by rob id
// ======================================================================

localparam int NUM_ROB = 1 << ROB_ID_W;

t_addr exp_addr [NUM_ROB];
logic  pending  [NUM_ROB];  // dispatched, completion not seen yet.
logic  flushed  [NUM_ROB];  // dropped by a nuke, must never complete.
int    disp_count;
int    done_count;
int    flush_count;

function automatic void clear_books();
    for (int i = 0; i < NUM_ROB; i++) begin
        exp_addr[i] = '0;
        pending[i]  = 1'b0;
        flushed[i]  = 1'b0;
    end
    disp_count  = 0;
    done_count  = 0;
    flush_count = 0;
endfunction

function automatic void mark_dispatched(input t_rob_id rob);
    pending[rob] = 1'b1;
    flushed[rob] = 1'b0;  // id reused by a fresh load.
    disp_count   = disp_count + 1;
endfunction

function automatic void set_expected_addr(input t_rob_id rob, input t_addr addr);
    exp_addr[rob] = addr;
endfunction

function automatic void mark_completed(input t_rob_id rob);
    pending[rob] = 1'b0;
    done_count   = done_count + 1;
endfunction

function automatic void flush_outstanding();
    for (int i = 0; i < NUM_ROB; i++) begin
        if (pending[i]) begin
            pending[i]  = 1'b0;
            flushed[i]  = 1'b1;
            flush_count = flush_count + 1;
        end
    end
endfunction

function automatic int count_pending();
    int n;
    n = 0;
    for (int i = 0; i < NUM_ROB; i++) begin
        if (pending[i]) begin
            n = n + 1;
        end
    end
    return n;
endfunction

`endif

// ==== testbench/mem_tb.sv ====
`timescale 1ns/1ns

module mem_tb;

import mem_pkg::*;

localparam int LQ_DEPTH    = 8;
localparam int L1_SETS     = 16;
localparam int N_RANDOM    = 64;
localparam int N_NUKE      = 4;
localparam int ADDR_RANGE  = 48;  // three tags per set.
localparam int TOTAL_LOADS = 2 + N_RANDOM + LQ_DEPTH + 2 * N_NUKE;

logic    clk;
logic    reset;
logic    disp_valid;
t_rob_id disp_rob_id;
logic    disp_ready;
logic    iss_valid;
t_rob_id iss_rob_id;
t_addr   iss_addr;
logic    nuke_valid;
logic    complete_valid;
t_rob_id complete_rob_id;
t_data   complete_data;
logic    fill_req;
t_addr   fill_addr;
logic    fill_ack;
t_data   fill_data;

string   test_name;
t_rob_id rob_next;
int      fill_count;      // rising edges of fill_req.
t_addr   last_fill_addr;
logic    req_seen;
logic    ack_seen;        // ack level while fill_req was low.
t_addr   req_addr;

`include "mem_tb_ref.svh"

mem #(.LQ_DEPTH(LQ_DEPTH), .L1_SETS(L1_SETS)) i_mem (
    .clk,
    .reset,
    .disp_valid,
    .disp_rob_id,
    .disp_ready,
    .iss_valid,
    .iss_rob_id,
    .iss_addr,
    .nuke_valid,
    .complete_valid,
    .complete_rob_id,
    .complete_data,
    .fill_req,
    .fill_addr,
    .fill_ack,
    .fill_data
);

initial clk = 1'b0;
always #50 clk = ~clk;

task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("Regression failed");
    $fatal(1, "stopped at first error.");
endtask

// ======================================================================
// stimulus helpers, called and returning on a falling edge
// ======================================================================

task automatic dispatch_load(input t_rob_id rob);
    disp_valid  = 1'b1;
    disp_rob_id = rob;
    while (!disp_ready) begin
        @(negedge clk);
    end
    mark_dispatched(rob);  // taken at the coming rising edge.
    @(negedge clk);
    disp_valid = 1'b0;
endtask

task automatic issue_load(input t_rob_id rob, input t_addr addr);
    set_expected_addr(rob, addr);
    iss_valid  = 1'b1;
    iss_rob_id = rob;
    iss_addr   = addr;
    @(negedge clk);
    iss_valid = 1'b0;
endtask

task automatic nuke_all();
    nuke_valid = 1'b1;
    @(negedge clk);
    nuke_valid = 1'b0;
endtask

task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk);
endtask

task automatic wait_drain();
    while (count_pending() != 0) begin
        @(negedge clk);
    end
endtask

// next rob id that has no load in flight.
function automatic t_rob_id pick_rob();
    t_rob_id rob;
    rob = rob_next;
    while (pending[rob]) begin
        rob = rob + ROB_ID_W'(1);
    end
    rob_next = rob + ROB_ID_W'(1);
    return rob;
endfunction

// ======================================================================
// tests
// ======================================================================

initial begin
    t_rob_id rob;
    t_addr   addr;
    int      fills_before;
    t_rob_id burst [LQ_DEPTH];
    void'($urandom(90713));
    reset       = 1'b1;
    disp_valid  = 1'b0;
    disp_rob_id = '0;
    iss_valid   = 1'b0;
    iss_rob_id  = '0;
    iss_addr    = '0;
    nuke_valid  = 1'b0;
    test_name   = "reset";
    rob_next    = '0;
    clear_books();
    repeat (10) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);

    test_name    = "cold_miss";
    fills_before = fill_count;
    rob          = pick_rob();
    dispatch_load(rob);
    issue_load(rob, 16'h0123);
    wait_drain();
    assert (fill_count == fills_before + 1) else stop_on_error($sformatf(
        "cold miss raised %0d fill requests instead of one", fill_count - fills_before));
    assert (last_fill_addr == 16'h0123) else stop_on_error($sformatf(
        "mismatch %s fill_addr expected %h actual %h", test_name, 16'h0123, last_fill_addr));

    test_name    = "hit";
    fills_before = fill_count;
    rob          = pick_rob();
    dispatch_load(rob);
    issue_load(rob, 16'h0123);
    wait_drain();
    assert (fill_count == fills_before) else stop_on_error(
        "a load that hits raised a fill request");

    // small address range, so hits, misses and set conflicts mix.
    test_name = "random_mix";
    for (int i = 0; i < N_RANDOM; i++) begin
        rob  = pick_rob();
        addr = t_addr'($urandom_range(ADDR_RANGE - 1));
        dispatch_load(rob);
        issue_load(rob, addr);
        wait_cycles($urandom_range(2));
    end
    wait_drain();

    test_name = "back_pressure";
    for (int i = 0; i < LQ_DEPTH; i++) begin
        burst[i] = pick_rob();
        dispatch_load(burst[i]);
    end
    for (int i = 0; i < 5; i++) begin
        assert (!disp_ready) else stop_on_error("disp_ready stayed high with a full load queue");
        wait_cycles(1);
    end
    for (int i = 0; i < LQ_DEPTH; i++) begin
        issue_load(burst[i], t_addr'($urandom_range(ADDR_RANGE - 1)));
    end
    wait_drain();
    wait_cycles(1);
    assert (disp_ready) else stop_on_error("disp_ready did not return after the queue drained");

    // two loads in flight, two never issued, then flush everything.
    test_name = "nuke";
    for (int i = 0; i < N_NUKE; i++) begin
        burst[i] = pick_rob();
        dispatch_load(burst[i]);
    end
    issue_load(burst[0], 16'h0200);
    issue_load(burst[1], 16'h0310);
    nuke_all();
    wait_cycles(40);
    assert (flush_count == N_NUKE) else stop_on_error($sformatf(
        "mismatch %s flushed loads expected %0d actual %0d", test_name, N_NUKE, flush_count));

    test_name = "after_nuke";
    for (int i = 0; i < N_NUKE; i++) begin
        rob  = pick_rob();
        addr = 16'h0200 + t_addr'(i * 16);
        dispatch_load(rob);
        issue_load(rob, addr);
    end
    wait_drain();

    wait_cycles(20);
    test_name = "end_of_run";
    if (disp_count == TOTAL_LOADS && done_count == TOTAL_LOADS - N_NUKE) begin
        $display("Regression passed");
        $finish;
    end else begin
        stop_on_error($sformatf(
            "mismatch %s dispatched/completed expected %0d/%0d actual %0d/%0d",
            test_name, TOTAL_LOADS, TOTAL_LOADS - N_NUKE, disp_count, done_count));
    end
end

// ======================================================================
// fill responder
// ======================================================================

initial begin
    fill_ack  = 1'b0;
    fill_data = '0;
    forever begin
        @(negedge clk);
        if (!reset && fill_req) begin
            repeat ($urandom_range(4)) @(negedge clk);
            fill_data = ref_mem_word(fill_addr);
            fill_ack  = 1'b1;
            do begin
                @(negedge clk);
            end while (fill_req);
            repeat ($urandom_range(3)) @(negedge clk);
            fill_ack = 1'b0;  // port free for the next request.
        end
    end
end

// ======================================================================
// checkers
// ======================================================================

task automatic check_completion();
    t_rob_id rob;
    t_data   expected;
    rob = complete_rob_id;
    assert (!flushed[rob]) else stop_on_error($sformatf(
        "rob id %0d completed after it was flushed by a nuke", rob));
    assert (pending[rob]) else stop_on_error($sformatf(
        "rob id %0d completed without an outstanding load", rob));
    expected = ref_mem_word(exp_addr[rob]);
    assert (complete_data == expected) else stop_on_error($sformatf(
        "mismatch %s rob %0d addr %h expected %h actual %h",
        test_name, rob, exp_addr[rob], expected, complete_data));
    mark_completed(rob);
endtask

always @(posedge clk) begin
    if (!reset) begin
        if (complete_valid) begin
            check_completion();
        end
        if (nuke_valid) begin
            flush_outstanding();  // a completion in the nuke cycle still counts.
        end
    end
end

// four-phase rules on the fill port.
always @(posedge clk) begin
    if (reset) begin
        req_seen   = 1'b0;
        ack_seen   = 1'b0;
        fill_count = 0;
    end else begin
        if (fill_req && !req_seen) begin
            assert (!ack_seen) else stop_on_error("fill_req rose while fill_ack was still high");
            fill_count     = fill_count + 1;
            last_fill_addr = fill_addr;
        end
        if (fill_req && req_seen) begin
            assert (fill_addr == req_addr) else stop_on_error(
                "fill_addr changed while fill_req was high");
        end
        req_seen = fill_req;
        ack_seen = fill_ack;
        req_addr = fill_addr;
    end
end

initial begin
    repeat (TOTAL_LOADS * 200 + 1000) @(posedge clk);
    stop_on_error($sformatf("timeout with %0d loads still outstanding", count_pending()));
end

endmodule
